//--- hdl/gpio_cfg_pkg.sv
// GPIO width, register index map, pad configuration struct and interrupt edge select
package gpio_cfg_pkg;

    // Number of pins, one per data bit
    localparam int GPIO_W = 32;

    // --------------------------------------------------------------------------
    // Register map
    // --------------------------------------------------------------------------

    // Word index, taken from adr[5:2]
    typedef enum logic [3:0] {
        REG_OUT      = 4'd0,  // Output value
        REG_DIR      = 4'd1,  // Direction, 1 = output
        REG_IN       = 4'd2,  // Synchronized pin state, read only
        REG_OD       = 4'd3,  // Open drain select
        REG_PU       = 4'd4,  // Pull-up enable
        REG_PD       = 4'd5,  // Pull-down enable
        REG_IRQ_EN   = 4'd6,  // Interrupt enable mask
        REG_IRQ_EDGE = 4'd7,  // Edge select per pin
        REG_IRQ_STAT = 4'd8   // Sticky status, write one to clear
    } gpio_reg_e;

    // Count of decoded words
    // Indices at or above this return a bus error
    localparam int REG_COUNT = 9;

    // --------------------------------------------------------------------------
    // Pad side
    // --------------------------------------------------------------------------

    // Static pad setup held in the register block
    // All fields zero after reset, so every pin starts as an input
    typedef struct packed {
        logic [GPIO_W-1:0] out;  // Value for pins that drive
        logic [GPIO_W-1:0] dir;  // 1 = output
        logic [GPIO_W-1:0] od;   // 1 = open drain
        logic [GPIO_W-1:0] pu;   // Pull-up request
        logic [GPIO_W-1:0] pd;   // Pull-down request
    } pad_cfg_t;

    // Meaning of one REG_IRQ_EDGE bit
    typedef enum logic {
        EDGE_RISE = 1'b0,
        EDGE_FALL = 1'b1
    } irq_edge_e;

endpackage

//--- hdl/gpio_bus_pkg.sv
// Wishbone request and response structs, register access structs and access opcodes
package gpio_bus_pkg;

    // --------------------------------------------------------------------------
    // Wishbone side
    // --------------------------------------------------------------------------

    // Kind of register access sent to the register block
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,  // No access this cycle
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } bus_op_e;

    // Flat slave inputs gathered in one place
    // stb here is already qualified with cyc
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic        we;
        logic [3:0]  sel;
        logic        stb;
    } wb_req_t;

    // Registered slave outputs
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
        logic        err;
    } wb_rsp_t;

    // --------------------------------------------------------------------------
    // Register block side
    // --------------------------------------------------------------------------

    // One access, only issued for aligned and mapped words
    typedef struct packed {
        bus_op_e                 op;
        gpio_cfg_pkg::gpio_reg_e idx;
        logic [31:0]             wdata;
        logic [3:0]              be;
    } reg_req_t;

    // Combinational answer, same cycle as the request
    typedef struct packed {
        logic [31:0] rdata;
        logic        valid;  // Access hit a decoded word
        logic        miss;   // Nothing decoded, becomes err
    } reg_rsp_t;

endpackage

//--- hdl/gpio_wb.sv
// Wishbone B4 classic slave adapter with address checks and registered ack, err and read data
module gpio_wb (
    input  logic                   wb_clk_i,
    input  logic                   rst_n_i,
    input  logic [31:0]            wb_adr_i,
    input  logic [31:0]            wb_dat_i,
    input  logic                   wb_we_i,
    input  logic [3:0]             wb_sel_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_cyc_i,
    output logic [31:0]            wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   wb_err_o,
    output gpio_bus_pkg::reg_req_t reg_req_o,
    input  gpio_bus_pkg::reg_rsp_t reg_rsp_i
);
    import gpio_bus_pkg::*;
    import gpio_cfg_pkg::*;

    wb_req_t wb_req;
    wb_rsp_t wb_rsp_d;
    wb_rsp_t wb_rsp_q;
    logic    rsp_pending;
    logic    accept;
    logic    addr_misaligned;
    logic    addr_out_of_map;
    logic    idx_out_of_range;
    logic    addr_miss;

    // Gather the flat port set
    always_comb begin
        wb_req.adr = wb_adr_i;
        wb_req.dat = wb_dat_i;
        wb_req.we  = wb_we_i;
        wb_req.sel = wb_sel_i;
        wb_req.stb = wb_cyc_i & wb_stb_i;
    end

    // --------------------------------------------------------------------------
    // Acceptance and address checks
    // --------------------------------------------------------------------------

    // Master still holds the request during the ack cycle
    assign rsp_pending = wb_rsp_q.ack | wb_rsp_q.err;
    assign accept      = wb_req.stb & ~rsp_pending;

    // Word accesses only
    assign addr_misaligned  = wb_req.adr[1:0] != 2'b00;
    // Map spans 16 words, anything above is unmapped
    assign addr_out_of_map  = wb_req.adr[31:6] != '0;
    assign idx_out_of_range = wb_req.adr[5:2] >= 4'(REG_COUNT);
    assign addr_miss        = addr_misaligned | addr_out_of_map | idx_out_of_range;

    // Bad addresses go out as OP_IDLE, so the register block reports a miss
    always_comb begin
        reg_req_o.op    = OP_IDLE;
        reg_req_o.idx   = gpio_reg_e'(wb_req.adr[5:2]);
        reg_req_o.wdata = wb_req.dat;
        reg_req_o.be    = wb_req.sel;
        if (accept && !addr_miss) begin
            reg_req_o.op = wb_req.we ? OP_WRITE : OP_READ;
        end
    end

    // --------------------------------------------------------------------------
    // Response, one cycle after acceptance
    // --------------------------------------------------------------------------

    // Read data sampled in the accept cycle, zero for writes and errors
    always_comb begin
        wb_rsp_d.ack = accept & reg_rsp_i.valid;
        wb_rsp_d.err = accept & reg_rsp_i.miss;
        wb_rsp_d.dat = (accept && reg_rsp_i.valid && !wb_req.we) ? reg_rsp_i.rdata : '0;
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            wb_rsp_q <= '0;
        end else begin
            wb_rsp_q <= wb_rsp_d;
        end
    end

    assign wb_dat_o = wb_rsp_q.dat;
    assign wb_ack_o = wb_rsp_q.ack;
    assign wb_err_o = wb_rsp_q.err;

endmodule

//--- hdl/gpio_regs.sv
// GPIO register file with byte-enabled writes, read mux, edge detection and interrupt status
module gpio_regs (
    input  logic                                wb_clk_i,
    input  logic                                rst_n_i,
    input  gpio_bus_pkg::reg_req_t              reg_req_i,
    output gpio_bus_pkg::reg_rsp_t              reg_rsp_o,
    input  logic [gpio_cfg_pkg::GPIO_W-1:0]     pin_sync_i,
    output gpio_cfg_pkg::pad_cfg_t              pad_cfg_o,
    output logic                                intr_o
);
    import gpio_bus_pkg::*;
    import gpio_cfg_pkg::*;

    // Writable state
    pad_cfg_t          cfg_q;
    logic [GPIO_W-1:0] irq_en_q;
    logic [GPIO_W-1:0] irq_edge_q;
    logic [GPIO_W-1:0] irq_stat_q;
    // Edge detection
    logic [GPIO_W-1:0] pin_prev_q;
    logic [GPIO_W-1:0] pin_rise;
    logic [GPIO_W-1:0] pin_fall;
    logic [GPIO_W-1:0] edge_hit;
    logic [GPIO_W-1:0] stat_clr;
    logic              intr_q;
    // Bus side
    logic              reg_wr;
    logic              idx_hit;
    logic [31:0]       rdata;
    logic [GPIO_W-1:0] wr_mask;

    // Old value with the selected bytes replaced by write data
    function automatic logic [GPIO_W-1:0] byte_merge(
        input logic [GPIO_W-1:0] old_val,
        input logic [GPIO_W-1:0] new_val,
        input logic [GPIO_W-1:0] mask
    );
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    assign reg_wr = reg_req_i.op == OP_WRITE;

    // One sel bit per byte lane
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            wr_mask[8*b +: 8] = {8{reg_req_i.be[b]}};
        end
    end

    // --------------------------------------------------------------------------
    // Writable registers
    // --------------------------------------------------------------------------

    // REG_IN and REG_IRQ_STAT are not written here
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            cfg_q      <= '0;
            irq_en_q   <= '0;
            irq_edge_q <= '0;
        end else if (reg_wr) begin
            case (reg_req_i.idx)
                REG_OUT:      cfg_q.out  <= byte_merge(cfg_q.out, reg_req_i.wdata, wr_mask);
                REG_DIR:      cfg_q.dir  <= byte_merge(cfg_q.dir, reg_req_i.wdata, wr_mask);
                REG_OD:       cfg_q.od   <= byte_merge(cfg_q.od, reg_req_i.wdata, wr_mask);
                REG_PU:       cfg_q.pu   <= byte_merge(cfg_q.pu, reg_req_i.wdata, wr_mask);
                REG_PD:       cfg_q.pd   <= byte_merge(cfg_q.pd, reg_req_i.wdata, wr_mask);
                REG_IRQ_EN:   irq_en_q   <= byte_merge(irq_en_q, reg_req_i.wdata, wr_mask);
                REG_IRQ_EDGE: irq_edge_q <= byte_merge(irq_edge_q, reg_req_i.wdata, wr_mask);
                default: begin
                end
            endcase
        end
    end

    assign pad_cfg_o = cfg_q;

    // --------------------------------------------------------------------------
    // Edge detection and status
    // --------------------------------------------------------------------------

    assign pin_rise = pin_sync_i & ~pin_prev_q;
    assign pin_fall = ~pin_sync_i & pin_prev_q;

    // Per pin edge select
    always_comb begin
        for (int i = 0; i < GPIO_W; i++) begin
            if (irq_edge_e'(irq_edge_q[i]) == EDGE_FALL) begin
                edge_hit[i] = pin_fall[i];
            end else begin
                edge_hit[i] = pin_rise[i];
            end
        end
    end

    // Ones written to REG_IRQ_STAT clear, byte enables apply
    assign stat_clr = (reg_wr && reg_req_i.idx == REG_IRQ_STAT) ? reg_req_i.wdata & wr_mask : '0;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            pin_prev_q <= '0;
            irq_stat_q <= '0;
            intr_q     <= 1'b0;
        end else begin
            pin_prev_q <= pin_sync_i;
            // New edge beats a clear in the same cycle
            irq_stat_q <= (irq_stat_q & ~stat_clr) | edge_hit;
            intr_q     <= |(irq_stat_q & irq_en_q);
        end
    end

    assign intr_o = intr_q;

    // --------------------------------------------------------------------------
    // Read mux
    // --------------------------------------------------------------------------

    // Only idx is decoded here, address checks live in the bus adapter
    always_comb begin
        idx_hit = 1'b1;
        case (reg_req_i.idx)
            REG_OUT:      rdata = cfg_q.out;
            REG_DIR:      rdata = cfg_q.dir;
            REG_IN:       rdata = pin_sync_i;
            REG_OD:       rdata = cfg_q.od;
            REG_PU:       rdata = cfg_q.pu;
            REG_PD:       rdata = cfg_q.pd;
            REG_IRQ_EN:   rdata = irq_en_q;
            REG_IRQ_EDGE: rdata = irq_edge_q;
            REG_IRQ_STAT: rdata = irq_stat_q;
            default: begin
                rdata   = '0;
                idx_hit = 1'b0;
            end
        endcase
    end

    // An idle request is a miss, the adapter only looks at it when accepting
    always_comb begin
        reg_rsp_o.rdata = rdata;
        reg_rsp_o.valid = (reg_req_i.op != OP_IDLE) && idx_hit;
        reg_rsp_o.miss  = !reg_rsp_o.valid;
    end

endmodule

//--- hdl/gpio_wrapper.sv
// Pad drive for push-pull and open-drain pins, pull forwarding and two-flop input synchronizer
module gpio_wrapper (
    input  logic                            wb_clk_i,
    input  logic                            rst_n_i,
    input  gpio_cfg_pkg::pad_cfg_t          pad_cfg_i,
    input  logic [gpio_cfg_pkg::GPIO_W-1:0] pad_i,
    output logic [gpio_cfg_pkg::GPIO_W-1:0] pad_o,
    output logic [gpio_cfg_pkg::GPIO_W-1:0] pad_oe_o,
    output logic [gpio_cfg_pkg::GPIO_W-1:0] pad_pu_o,
    output logic [gpio_cfg_pkg::GPIO_W-1:0] pad_pd_o,
    output logic [gpio_cfg_pkg::GPIO_W-1:0] pin_sync_o
);
    import gpio_cfg_pkg::*;

    logic [GPIO_W-1:0] drive_pp;
    logic [GPIO_W-1:0] drive_od;
    logic [GPIO_W-1:0] pad_oe;
    logic [GPIO_W-1:0] pad_meta_q;
    logic [GPIO_W-1:0] pad_sync_q;

    // --------------------------------------------------------------------------
    // Output side
    // --------------------------------------------------------------------------

    // Push-pull output drives both levels
    assign drive_pp = pad_cfg_i.dir & ~pad_cfg_i.od;
    // Open drain only pulls low, released when out is 1
    assign drive_od = pad_cfg_i.dir & pad_cfg_i.od & ~pad_cfg_i.out;
    assign pad_oe   = drive_pp | drive_od;

    // Driven open-drain pins carry 0
    assign pad_o    = drive_pp & pad_cfg_i.out;
    assign pad_oe_o = pad_oe;

    // Pulls only on released pins
    assign pad_pu_o = pad_cfg_i.pu & ~pad_oe;
    assign pad_pd_o = pad_cfg_i.pd & ~pad_oe;

    // --------------------------------------------------------------------------
    // Input side
    // --------------------------------------------------------------------------

    // Two stages, pad input reaches pin_sync_o after two edges
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            pad_meta_q <= '0;
            pad_sync_q <= '0;
        end else begin
            pad_meta_q <= pad_i;
            pad_sync_q <= pad_meta_q;
        end
    end

    assign pin_sync_o = pad_sync_q;

endmodule

//--- hdl/gpio_top.sv
// GPIO peripheral top level with flat Wishbone and split pad ports
module gpio_top (
    input  logic                            wb_clk_i,
    input  logic                            rst_n_i,
    input  logic [31:0]                     wb_adr_i,
    input  logic [31:0]                     wb_dat_i,
    input  logic                            wb_we_i,
    input  logic [3:0]                      wb_sel_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_cyc_i,
    output logic [31:0]                     wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o,
    input  logic [gpio_cfg_pkg::GPIO_W-1:0] pad_i,
    output logic [gpio_cfg_pkg::GPIO_W-1:0] pad_o,
    output logic [gpio_cfg_pkg::GPIO_W-1:0] pad_oe_o,
    output logic [gpio_cfg_pkg::GPIO_W-1:0] pad_pu_o,
    output logic [gpio_cfg_pkg::GPIO_W-1:0] pad_pd_o,
    output logic                            intr_o
);
    import gpio_bus_pkg::*;
    import gpio_cfg_pkg::*;

    // Adapter to register block
    reg_req_t          reg_req;
    reg_rsp_t          reg_rsp;
    // Register block to pad logic and back
    pad_cfg_t          pad_cfg;
    logic [GPIO_W-1:0] pin_sync;

    // Bus handshake and address checks
    gpio_wb gpio_wb_i (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_we_i   (wb_we_i),
        .wb_sel_i  (wb_sel_i),
        .wb_stb_i  (wb_stb_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .wb_err_o  (wb_err_o),
        .reg_req_o (reg_req),
        .reg_rsp_i (reg_rsp)
    );

    // Registers and interrupt logic
    gpio_regs gpio_regs_i (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .reg_req_i  (reg_req),
        .reg_rsp_o  (reg_rsp),
        .pin_sync_i (pin_sync),
        .pad_cfg_o  (pad_cfg),
        .intr_o     (intr_o)
    );

    // Pad drive and input synchronizer
    gpio_wrapper gpio_wrapper_i (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .pad_cfg_i  (pad_cfg),
        .pad_i      (pad_i),
        .pad_o      (pad_o),
        .pad_oe_o   (pad_oe_o),
        .pad_pu_o   (pad_pu_o),
        .pad_pd_o   (pad_pd_o),
        .pin_sync_o (pin_sync)
    );

endmodule

//--- verif/gpio_tb.sv
// Testbench for the GPIO peripheral with clock, reset, Wishbone master, pad model and stimulus table
module gpio_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import gpio_cfg_pkg::*;

    // Step kinds of the stimulus table
    typedef enum logic [3:0] {
        ST_QUIET,    // Handshake, pad and interrupt outputs all low
        ST_WRITE,    // Write, expect ack
        ST_READ,     // Read, expect ack and data
        ST_BAD_WR,   // Write, expect err and no ack
        ST_BAD_RD,   // Read, expect err and no ack
        ST_PIN,      // wdata picks forced pins, ext is their level
        ST_POLL_IN,  // Read REG_IN until it matches
        ST_INTR,     // Wait for intr_o to reach exp[0]
        ST_PADS      // Pad outputs against the register mirror
    } step_e;

    typedef struct packed {
        step_e       kind;
        logic [2:0]  test;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [31:0] ext;
        logic [31:0] exp;
    } step_t;

    logic              clk;
    logic              rst_n;
    logic [31:0]       wb_adr;
    logic [31:0]       wb_dat_w;
    logic              wb_we;
    logic [3:0]        wb_sel;
    logic              wb_stb;
    logic              wb_cyc;
    logic [31:0]       wb_dat_r;
    logic              wb_ack;
    logic              wb_err;
    logic [GPIO_W-1:0] pad_in;
    logic [GPIO_W-1:0] pad_out;
    logic [GPIO_W-1:0] pad_oe;
    logic [GPIO_W-1:0] pad_pu;
    logic [GPIO_W-1:0] pad_pd;
    logic              intr;
    // External drivers on released pins
    logic [GPIO_W-1:0] ext_en;
    logic [GPIO_W-1:0] ext_val;

    step_t             steps[$];
    logic [31:0]       shadow [16];
    string             test_names [6];
    int                seed;
    int                errors;
    int                checks;

    gpio_top gpio_top_i (
        .wb_clk_i (clk),
        .rst_n_i  (rst_n),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_we_i  (wb_we),
        .wb_sel_i (wb_sel),
        .wb_stb_i (wb_stb),
        .wb_cyc_i (wb_cyc),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .wb_err_o (wb_err),
        .pad_i    (pad_in),
        .pad_o    (pad_out),
        .pad_oe_o (pad_oe),
        .pad_pu_o (pad_pu),
        .pad_pd_o (pad_pd),
        .intr_o   (intr)
    );

    // Driven pins read back, released pins see the board or their pull-up
    assign pad_in = (pad_oe & pad_out) | (~pad_oe & ext_en & ext_val)
                  | (~pad_oe & ~ext_en & pad_pu);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] reg_addr(input gpio_reg_e r);
        return {26'd0, r, 2'b00};
    endfunction

    // Old word with the lanes selected by be taken from new_val
    function automatic logic [31:0] lane_merge(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  be);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // One classic cycle with the request held until ack or err
    task automatic wb_cycle(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata,
                            output logic ack, output logic err);
        int cycles;
        cycles   = 0;
        ack      = 1'b0;
        err      = 1'b0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdata;
        wb_sel   = be;
        while (!ack && !err && cycles < 20) begin
            @(posedge clk);
            #2;
            ack   = wb_ack;
            err   = wb_err;
            rdata = wb_dat_r;
            cycles++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        assert (ack || err) else begin
            $display("Timeout at %0t ns: no ack or err for the access to %h", $time, addr);
            errors++;
        end
    endtask

    task automatic wb_write(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output logic ack, output logic err);
        logic [31:0] unused_rdata;
        wb_cycle(1'b1, addr, wdata, be, unused_rdata, ack, err);
    endtask

    task automatic wb_read(input logic [31:0] addr, output logic [31:0] rdata,
                           output logic ack, output logic err);
        wb_cycle(1'b0, addr, '0, 4'hf, rdata, ack, err);
    endtask

    // Expected pad outputs per pin from the mirrored configuration
    task automatic check_pads();
        logic [31:0] exp_oe;
        logic [31:0] exp_o;
        logic [31:0] exp_pu;
        logic [31:0] exp_pd;
        for (int i = 0; i < GPIO_W; i++) begin
            exp_oe[i] = 1'b0;
            exp_o[i]  = 1'b0;
            if (shadow[REG_DIR][i]) begin
                if (!shadow[REG_OD][i]) begin
                    // Push-pull drives its out bit
                    exp_oe[i] = 1'b1;
                    exp_o[i]  = shadow[REG_OUT][i];
                end else if (!shadow[REG_OUT][i]) begin
                    // Open drain pulls low for a 0
                    exp_oe[i] = 1'b1;
                end
            end
            // Pulls reach only released pins
            exp_pu[i] = exp_oe[i] ? 1'b0 : shadow[REG_PU][i];
            exp_pd[i] = exp_oe[i] ? 1'b0 : shadow[REG_PD][i];
        end
        check_value("pad_oe_o", pad_oe, exp_oe);
        check_value("pad_o", pad_out, exp_o);
        check_value("pad_pu_o", pad_pu, exp_pu);
        check_value("pad_pd_o", pad_pd, exp_pd);
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] rdata;
        logic        ack;
        logic        err;
        int          polls;
        polls = 0;
        case (s.kind)
            ST_QUIET: begin
                // Let a previous ack run out
                @(posedge clk);
                #2;
                check_value("wb_ack_o", 32'(wb_ack), 0);
                check_value("wb_err_o", 32'(wb_err), 0);
                check_value("intr_o", 32'(intr), 0);
                check_value("pad_oe_o", pad_oe, 0);
                check_value("pad_pu_o", pad_pu, 0);
                check_value("pad_pd_o", pad_pd, 0);
            end
            ST_WRITE: begin
                wb_write(s.addr, s.wdata, s.be, ack, err);
                check_value("wb_ack_o", 32'(ack), 1);
                if (ack) begin
                    shadow[s.addr[5:2]] = lane_merge(shadow[s.addr[5:2]], s.wdata, s.be);
                end
            end
            ST_READ: begin
                wb_read(s.addr, rdata, ack, err);
                check_value("wb_ack_o", 32'(ack), 1);
                check_value("wb_dat_o", rdata, s.exp);
            end
            ST_BAD_WR, ST_BAD_RD: begin
                if (s.kind == ST_BAD_WR) begin
                    wb_write(s.addr, s.wdata, s.be, ack, err);
                end else begin
                    wb_read(s.addr, rdata, ack, err);
                end
                check_value("wb_err_o", 32'(err), 1);
                check_value("wb_ack_o", 32'(ack), 0);
            end
            ST_PIN: begin
                ext_en  = s.wdata;
                ext_val = s.ext;
            end
            ST_POLL_IN: begin
                rdata = ~s.exp;
                while (rdata !== s.exp && polls < 20) begin
                    wb_read(s.addr, rdata, ack, err);
                    polls++;
                end
                check_value("REG_IN", rdata, s.exp);
            end
            ST_INTR: begin
                while (intr !== s.exp[0] && polls < 20) begin
                    @(posedge clk);
                    #2;
                    polls++;
                end
                check_value("intr_o", 32'(intr), s.exp);
            end
            ST_PADS: check_pads();
            default: begin
            end
        endcase
    endtask

    function automatic void add_step(input step_e kind, input int test, input logic [31:0] addr,
                                     input logic [31:0] wdata, input logic [3:0] be,
                                     input logic [31:0] ext, input logic [31:0] exp);
        steps.push_back(step_t'{kind, 3'(test), addr, wdata, be, ext, exp});
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------

    function automatic void build_table();
        gpio_reg_e   rw_regs [7] = '{REG_OUT, REG_DIR, REG_OD, REG_PU, REG_PD,
                                     REG_IRQ_EN, REG_IRQ_EDGE};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        add_step(ST_QUIET, 0, 0, 0, 4'h0, 0, 0);
        // Full write, then a partial one with random lanes
        foreach (rw_regs[r]) begin
            a   = $random(seed);
            b   = $random(seed);
            rnd = $random(seed);
            add_step(ST_WRITE, 1, reg_addr(rw_regs[r]), a, 4'hf, 0, 0);
            add_step(ST_READ, 1, reg_addr(rw_regs[r]), 0, 4'hf, 0, a);
            add_step(ST_WRITE, 1, reg_addr(rw_regs[r]), b, rnd[3:0], 0, 0);
            add_step(ST_READ, 1, reg_addr(rw_regs[r]), 0, 4'hf, 0, lane_merge(a, b, rnd[3:0]));
        end
        // All pins back to inputs, then REG_IN must ignore a write
        foreach (rw_regs[r]) begin
            add_step(ST_WRITE, 1, reg_addr(rw_regs[r]), 0, 4'hf, 0, 0);
        end
        add_step(ST_POLL_IN, 1, reg_addr(REG_IN), 0, 4'hf, 0, 0);
        add_step(ST_WRITE, 1, reg_addr(REG_IN), $random(seed), 4'hf, 0, 0);
        add_step(ST_READ, 1, reg_addr(REG_IN), 0, 4'hf, 0, 0);
        add_step(ST_WRITE, 1, reg_addr(REG_IRQ_STAT), 32'hffff_ffff, 4'hf, 0, 0);
        add_step(ST_READ, 1, reg_addr(REG_IRQ_STAT), 0, 4'hf, 0, 0);

        // Misaligned, index 9 and 15, above the map, high address bit
        add_step(ST_WRITE, 2, reg_addr(REG_IRQ_EDGE), 32'h5a3c_96e1, 4'hf, 0, 0);
        add_step(ST_BAD_WR, 2, 32'h0000_001d, 32'hffff_ffff, 4'hf, 0, 0);
        add_step(ST_BAD_WR, 2, 32'h0000_0024, 32'hffff_ffff, 4'hf, 0, 0);
        add_step(ST_BAD_WR, 2, 32'h0000_003c, 32'hffff_ffff, 4'hf, 0, 0);
        add_step(ST_BAD_WR, 2, 32'h0000_0040, 32'hffff_ffff, 4'hf, 0, 0);
        add_step(ST_BAD_RD, 2, 32'h0000_0102, 0, 4'hf, 0, 0);
        add_step(ST_BAD_RD, 2, 32'h8000_001c, 0, 4'hf, 0, 0);
        add_step(ST_READ, 2, reg_addr(REG_IRQ_EDGE), 0, 4'hf, 0, 32'h5a3c_96e1);
        add_step(ST_READ, 2, reg_addr(REG_OUT), 0, 4'hf, 0, 0);

        // Pins 0-3 push-pull, 4-7 open drain, pull-ups on 4-11, pull-downs on 0-3 and 12-15
        add_step(ST_WRITE, 3, reg_addr(REG_OUT), 32'h0000_00a5, 4'hf, 0, 0);
        add_step(ST_WRITE, 3, reg_addr(REG_OD), 32'h0000_00f0, 4'hf, 0, 0);
        add_step(ST_WRITE, 3, reg_addr(REG_PU), 32'h0000_0ff0, 4'hf, 0, 0);
        add_step(ST_WRITE, 3, reg_addr(REG_PD), 32'h0000_f00f, 4'hf, 0, 0);
        add_step(ST_PADS, 3, 0, 0, 4'h0, 0, 0);
        add_step(ST_WRITE, 3, reg_addr(REG_DIR), 32'h0000_00ff, 4'hf, 0, 0);
        add_step(ST_PADS, 3, 0, 0, 4'h0, 0, 0);
        add_step(ST_POLL_IN, 3, reg_addr(REG_IN), 0, 4'hf, 0, 32'h0000_0fa5);
        // Swap which open-drain pins are released
        add_step(ST_WRITE, 3, reg_addr(REG_OUT), 32'h0000_005a, 4'hf, 0, 0);
        add_step(ST_PADS, 3, 0, 0, 4'h0, 0, 0);
        add_step(ST_POLL_IN, 3, reg_addr(REG_IN), 0, 4'hf, 0, 32'h0000_0f5a);

        // Pins 16-19 on rising edges, 20-23 on falling edges
        foreach (rw_regs[r]) begin
            add_step(ST_WRITE, 4, reg_addr(rw_regs[r]), 0, 4'hf, 0, 0);
        end
        add_step(ST_WRITE, 4, reg_addr(REG_IRQ_EDGE), 32'h00f0_0000, 4'hf, 0, 0);
        add_step(ST_PIN, 4, 0, 32'h00ff_0000, 4'h0, 32'h0000_0000, 0);
        add_step(ST_POLL_IN, 4, reg_addr(REG_IN), 0, 4'hf, 0, 0);
        add_step(ST_WRITE, 4, reg_addr(REG_IRQ_STAT), 32'hffff_ffff, 4'hf, 0, 0);
        add_step(ST_READ, 4, reg_addr(REG_IRQ_STAT), 0, 4'hf, 0, 0);
        add_step(ST_INTR, 4, 0, 0, 4'h0, 0, 0);
        add_step(ST_PIN, 4, 0, 32'h00ff_0000, 4'h0, 32'h00ff_0000, 0);
        add_step(ST_POLL_IN, 4, reg_addr(REG_IN), 0, 4'hf, 0, 32'h00ff_0000);
        add_step(ST_READ, 4, reg_addr(REG_IRQ_STAT), 0, 4'hf, 0, 32'h000f_0000);
        add_step(ST_INTR, 4, 0, 0, 4'h0, 0, 0);
        add_step(ST_WRITE, 4, reg_addr(REG_IRQ_EN), 32'h0011_0000, 4'hf, 0, 0);
        add_step(ST_INTR, 4, 0, 0, 4'h0, 0, 1);
        add_step(ST_PIN, 4, 0, 32'h00ff_0000, 4'h0, 32'h0000_0000, 0);
        add_step(ST_POLL_IN, 4, reg_addr(REG_IN), 0, 4'hf, 0, 0);
        add_step(ST_READ, 4, reg_addr(REG_IRQ_STAT), 0, 4'hf, 0, 32'h00ff_0000);

        // Bit 20 keeps intr_o up until it goes too
        add_step(ST_WRITE, 5, reg_addr(REG_IRQ_STAT), 32'h0001_0000, 4'hf, 0, 0);
        add_step(ST_READ, 5, reg_addr(REG_IRQ_STAT), 0, 4'hf, 0, 32'h00fe_0000);
        add_step(ST_INTR, 5, 0, 0, 4'h0, 0, 1);
        add_step(ST_WRITE, 5, reg_addr(REG_IRQ_STAT), 32'hffff_ffff, 4'b1011, 0, 0);
        add_step(ST_READ, 5, reg_addr(REG_IRQ_STAT), 0, 4'hf, 0, 32'h00fe_0000);
        add_step(ST_WRITE, 5, reg_addr(REG_IRQ_STAT), 32'h0010_0000, 4'hf, 0, 0);
        add_step(ST_INTR, 5, 0, 0, 4'h0, 0, 0);
        add_step(ST_READ, 5, reg_addr(REG_IRQ_STAT), 0, 4'hf, 0, 32'h00ee_0000);
        add_step(ST_WRITE, 5, reg_addr(REG_IRQ_STAT), 32'hffff_ffff, 4'hf, 0, 0);
        add_step(ST_READ, 5, reg_addr(REG_IRQ_STAT), 0, 4'hf, 0, 0);
        add_step(ST_PIN, 5, 0, 0, 4'h0, 0, 0);
        add_step(ST_QUIET, 5, 0, 0, 4'h0, 0, 0);
    endfunction

    initial begin
        int mark;
        int tests;
        rst_n    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_we    = 1'b0;
        wb_sel   = 4'h0;
        wb_stb   = 1'b0;
        wb_cyc   = 1'b0;
        ext_en   = '0;
        ext_val  = '0;
        seed     = 32'hc766_36b4;
        errors   = 0;
        checks   = 0;
        mark     = 0;
        tests    = 0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        test_names = '{"reset state", "register read-back", "bus errors", "pad drive",
                       "edge interrupts", "clearing"};
        build_table();

        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i]);
            if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
                $display("%s: %s, %0d errors", test_names[steps[i].test],
                         (errors == mark) ? "passed" : "failed", errors - mark);
                tests++;
                mark = errors;
            end
        end

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- src.f
hdl/gpio_cfg_pkg.sv
hdl/gpio_bus_pkg.sv
hdl/gpio_wb.sv
hdl/gpio_regs.sv
hdl/gpio_wrapper.sv
hdl/gpio_top.sv
verif/gpio_tb.sv

//--- run.sh
#!/bin/sh
# Build the GPIO testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=gpio_tb_sim
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module gpio_tb -Mdir "$BUILD_DIR" -o "$SIM_EXE"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if [ ! -s "$LOG" ]; then
    echo "Simulation log is empty"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
